// ==== verilog/noc_settings.svh ====
/* NoC build settings
   Mesh size, queue depth, camera addressing and flit widths */

`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// Mesh geometry, node address is {y, x}
`define NOC_NODES          4
`define NOC_NODE_BITS      2

`define NOC_PAYLOAD_WIDTH  32
`define NOC_FIFO_DEPTH     2     // Router inputs and camera queue

// Camera tile
`define CAM_NODE           3
`define CAM_DEST_NODE      0     // Where pixel words go
`define PIXELS_PER_FLIT    4

`endif

// ==== verilog/noc_pkg.sv ====
/* NoC shared types
   Flit layout, flit origin tag and router port numbering */

`include "noc_settings.svh"

package noc_pkg;

   // Node address, bit 0 is x and bit 1 is y
   typedef logic [`NOC_NODE_BITS-1:0] node_addr_t;

   typedef enum logic {
      FLIT_DATA  = 1'b0,   // Injected at a compute tile port
      FLIT_PIXEL = 1'b1    // Packed by the camera
   } flit_kind_e;

   // Single flit packet, the unit on every link
   typedef struct packed {
      node_addr_t                    dest;
      node_addr_t                    src;
      flit_kind_e                    kind;
      logic [`NOC_PAYLOAD_WIDTH-1:0] payload;
   } flit_t;

   // Router ports, 2x2 mesh needs one neighbour per dimension
   typedef enum logic [1:0] {
      PORT_LOCAL = 2'd0,
      PORT_X     = 2'd1,
      PORT_Y     = 2'd2
   } port_e;

endpackage

// ==== verilog/noc_fifo.sv ====
/* Flit FIFO
   Circular buffer with valid/ready on both sides */

`timescale 1ns/1ns

module noc_fifo #(
   parameter int DEPTH = 2
) (
   input  logic           clk,
   input  logic           arst_n_i,
   input  noc_pkg::flit_t in_flit_i,
   input  logic           in_valid_i,
   output logic           in_ready_o,
   output noc_pkg::flit_t out_flit_o,
   output logic           out_valid_o,
   input  logic           out_ready_i
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   noc_pkg::flit_t   mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             up_q;              // Low until first edge out of reset
   logic             wr_en, rd_en;

   assign in_ready_o  = up_q && (count_q != CNT_W'(DEPTH));
   assign out_valid_o = (count_q != '0);
   assign out_flit_o  = mem[rd_ptr_q];  // Head, valid the cycle after write

   assign wr_en = in_valid_i && in_ready_o;
   assign rd_en = out_valid_o && out_ready_i;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         up_q     <= 1'b0;
      end else begin
         up_q <= 1'b1;
         if (wr_en) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (rd_en) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         count_q <= count_q + CNT_W'(wr_en) - CNT_W'(rd_en);  // Both at once keeps fill
      end
   end

   // Storage
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr_q] <= in_flit_i;
      end
   end

endmodule

// ==== verilog/noc_router.sv ====
/* Three port mesh router
   Input FIFOs, XY routing, round-robin arbiter and register per output */

`timescale 1ns/1ns
`include "noc_settings.svh"

module noc_router #(
   parameter int NODE_ID = 0
) (
   input  logic                 clk,
   input  logic                 arst_n_i,
   input  noc_pkg::flit_t [2:0] in_flit_i,     // Indexed by port_e
   input  logic [2:0]           in_valid_i,
   output logic [2:0]           in_ready_o,
   output noc_pkg::flit_t [2:0] out_flit_o,
   output logic [2:0]           out_valid_o,
   input  logic [2:0]           out_ready_i
);

   localparam noc_pkg::node_addr_t MY_ADDR = noc_pkg::node_addr_t'(NODE_ID);

   noc_pkg::flit_t [2:0] head_flit;     // FIFO heads
   logic [2:0]           head_valid;
   logic [2:0]           head_pop;
   noc_pkg::port_e       route [3];     // Wanted output per head
   logic [2:0]           out_free;      // Output register can take a flit
   logic [2:0]           gnt_any;
   logic [1:0]           gnt_idx [3];   // Winning input per output
   logic [2:0]           load;
   noc_pkg::flit_t [2:0] out_flit_q;
   logic [2:0]           out_valid_q;
   logic [1:0]           rr_q [3];      // Round-robin start per output

   for (genvar p = 0; p < 3; p++) begin : g_in
      noc_fifo #(
         .DEPTH (`NOC_FIFO_DEPTH)
      ) u_fifo (
         .clk         (clk),
         .arst_n_i    (arst_n_i),
         .in_flit_i   (in_flit_i[p]),
         .in_valid_i  (in_valid_i[p]),
         .in_ready_o  (in_ready_o[p]),
         .out_flit_o  (head_flit[p]),
         .out_valid_o (head_valid[p]),
         .out_ready_i (head_pop[p])
      );

      // XY order, x first
      always_comb begin
         if (head_flit[p].dest[0] != MY_ADDR[0]) begin
            route[p] = noc_pkg::PORT_X;
         end else if (head_flit[p].dest[1] != MY_ADDR[1]) begin
            route[p] = noc_pkg::PORT_Y;
         end else begin
            route[p] = noc_pkg::PORT_LOCAL;  // Arrived
         end
      end

      // Leaves the FIFO when its output grabbed it
      assign head_pop[p] = head_valid[p] && load[route[p]] && (gnt_idx[route[p]] == 2'(p));
   end

   assign out_free = ~out_valid_q | out_ready_i;

   // Round-robin pick per output
   always_comb begin
      logic [2:0] sum;
      logic [1:0] cand;
      for (int o = 0; o < 3; o++) begin
         gnt_any[o] = 1'b0;
         gnt_idx[o] = rr_q[o];
         // Scan backwards so the first requester at or after the pointer wins
         for (int k = 2; k >= 0; k--) begin
            sum  = {1'b0, rr_q[o]} + 3'(k);
            cand = (sum >= 3'd3) ? 2'(sum - 3'd3) : sum[1:0];  // Mod 3
            if (head_valid[cand] && (route[cand] == noc_pkg::port_e'(o))) begin
               gnt_any[o] = 1'b1;
               gnt_idx[o] = cand;
            end
         end
         load[o] = gnt_any[o] && out_free[o];
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         out_valid_q <= '0;
         for (int o = 0; o < 3; o++) begin
            rr_q[o] <= 2'd0;
         end
      end else begin
         for (int o = 0; o < 3; o++) begin
            if (load[o]) begin
               out_valid_q[o] <= 1'b1;
               rr_q[o]        <= (gnt_idx[o] == 2'd2) ? 2'd0 : gnt_idx[o] + 2'd1;  // Past winner
            end else if (out_ready_i[o]) begin
               out_valid_q[o] <= 1'b0;         // Taken, nothing new
            end
         end
      end
   end

   // Output stage data
   always_ff @(posedge clk) begin
      for (int o = 0; o < 3; o++) begin
         if (load[o]) begin
            out_flit_q[o] <= head_flit[gnt_idx[o]];
         end
      end
   end

   assign out_flit_o  = out_flit_q;
   assign out_valid_o = out_valid_q;

endmodule

// ==== verilog/camera_tile.sv ====
/* Camera tile
   Packs strobed pixels into pixel flits, queues them, flags dropped words */

`timescale 1ns/1ns
`include "noc_settings.svh"

module camera_tile (
   input  logic           clk,
   input  logic           arst_n_i,
   input  logic [7:0]     pixel_i,
   input  logic           pixel_valid_i,
   input  logic           frame_start_i,
   output noc_pkg::flit_t out_flit_o,
   output logic           out_valid_o,
   input  logic           out_ready_i,
   output logic           overrun_o
);

   localparam int PIX_W = `NOC_PAYLOAD_WIDTH / `PIXELS_PER_FLIT;
   localparam int CNT_W = $clog2(`PIXELS_PER_FLIT);
   localparam logic [CNT_W-1:0] LAST_PIX = CNT_W'(`PIXELS_PER_FLIT - 1);

   logic [`NOC_PAYLOAD_WIDTH-1:0] word_q;     // Shift register, oldest pixel lowest
   logic [`NOC_PAYLOAD_WIDTH-1:0] word_next;
   logic [CNT_W-1:0]              cnt_q;      // Pixels in word so far
   logic [CNT_W-1:0]              cnt_base;
   logic                          word_done;
   logic                          q_ready;
   logic                          q_push;
   logic                          overrun_q;
   noc_pkg::flit_t                pix_flit;

   // Frame start throws away a partial word, same-cycle pixel opens the new one
   assign cnt_base  = frame_start_i ? '0 : cnt_q;
   assign word_next = {pixel_i, word_q[`NOC_PAYLOAD_WIDTH-1:PIX_W]};
   assign word_done = pixel_valid_i && (cnt_base == LAST_PIX);

   always_comb begin
      pix_flit.dest    = noc_pkg::node_addr_t'(`CAM_DEST_NODE);
      pix_flit.src     = noc_pkg::node_addr_t'(`CAM_NODE);
      pix_flit.kind    = noc_pkg::FLIT_PIXEL;
      pix_flit.payload = word_next;  // Includes the pixel of this cycle
   end

   assign q_push = word_done && q_ready;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cnt_q     <= '0;
         overrun_q <= 1'b0;
      end else begin
         if (pixel_valid_i) begin
            cnt_q <= word_done ? '0 : cnt_base + 1'b1;
         end else begin
            cnt_q <= cnt_base;
         end
         if (word_done && !q_ready) begin
            overrun_q <= 1'b1;  // Sticky until reset
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pixel_valid_i) begin
         word_q <= word_next;
      end
   end

   // Injection queue toward the router
   noc_fifo #(
      .DEPTH (`NOC_FIFO_DEPTH)
   ) u_queue (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .in_flit_i   (pix_flit),
      .in_valid_i  (q_push),
      .in_ready_o  (q_ready),
      .out_flit_o  (out_flit_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

   assign overrun_o = overrun_q;

endmodule

// ==== verilog/system_2x2_cam.sv ====
/* 2x2 mesh system
   Three external tile ports and a camera tile on node 3 */

`timescale 1ns/1ns
`include "noc_settings.svh"

module system_2x2_cam (
   input  logic                                clk,
   input  logic                                arst_n_i,
   input  noc_pkg::flit_t [`NOC_NODES-2:0]     inject_flit_i,   // Nodes 0 to 2
   input  logic [`NOC_NODES-2:0]               inject_valid_i,
   output logic [`NOC_NODES-2:0]               inject_ready_o,
   output noc_pkg::flit_t [`NOC_NODES-1:0]     eject_flit_o,    // All nodes
   output logic [`NOC_NODES-1:0]               eject_valid_o,
   input  logic [`NOC_NODES-1:0]               eject_ready_i,
   input  logic [7:0]                          pixel_i,
   input  logic                                pixel_valid_i,
   input  logic                                frame_start_i,
   output logic                                cam_overrun_o
);

   // Router side of each link, indexed [node][port]
   noc_pkg::flit_t [2:0] rt_in_flit   [`NOC_NODES];
   logic [2:0]           rt_in_valid  [`NOC_NODES];
   logic [2:0]           rt_in_ready  [`NOC_NODES];
   noc_pkg::flit_t [2:0] rt_out_flit  [`NOC_NODES];
   logic [2:0]           rt_out_valid [`NOC_NODES];
   logic [2:0]           rt_out_ready [`NOC_NODES];

   // Camera injection link
   noc_pkg::flit_t       cam_flit;
   logic                 cam_valid;
   logic                 cam_ready;

   for (genvar n = 0; n < `NOC_NODES; n++) begin : g_node
      noc_router #(
         .NODE_ID (n)
      ) u_router (
         .clk         (clk),
         .arst_n_i    (arst_n_i),
         .in_flit_i   (rt_in_flit[n]),
         .in_valid_i  (rt_in_valid[n]),
         .in_ready_o  (rt_in_ready[n]),
         .out_flit_o  (rt_out_flit[n]),
         .out_valid_o (rt_out_valid[n]),
         .out_ready_i (rt_out_ready[n])
      );

      // X neighbour differs in bit 0
      assign rt_in_flit[n][noc_pkg::PORT_X]   = rt_out_flit[n ^ 1][noc_pkg::PORT_X];
      assign rt_in_valid[n][noc_pkg::PORT_X]  = rt_out_valid[n ^ 1][noc_pkg::PORT_X];
      assign rt_out_ready[n][noc_pkg::PORT_X] = rt_in_ready[n ^ 1][noc_pkg::PORT_X];

      // Y neighbour differs in bit 1
      assign rt_in_flit[n][noc_pkg::PORT_Y]   = rt_out_flit[n ^ 2][noc_pkg::PORT_Y];
      assign rt_in_valid[n][noc_pkg::PORT_Y]  = rt_out_valid[n ^ 2][noc_pkg::PORT_Y];
      assign rt_out_ready[n][noc_pkg::PORT_Y] = rt_in_ready[n ^ 2][noc_pkg::PORT_Y];

      assign eject_flit_o[n]                      = rt_out_flit[n][noc_pkg::PORT_LOCAL];
      assign eject_valid_o[n]                     = rt_out_valid[n][noc_pkg::PORT_LOCAL];
      assign rt_out_ready[n][noc_pkg::PORT_LOCAL] = eject_ready_i[n];

      if (n == `CAM_NODE) begin : g_cam
         assign rt_in_flit[n][noc_pkg::PORT_LOCAL]  = cam_flit;
         assign rt_in_valid[n][noc_pkg::PORT_LOCAL] = cam_valid;
         assign cam_ready                           = rt_in_ready[n][noc_pkg::PORT_LOCAL];
      end else begin : g_ext
         assign rt_in_flit[n][noc_pkg::PORT_LOCAL]  = inject_flit_i[n];
         assign rt_in_valid[n][noc_pkg::PORT_LOCAL] = inject_valid_i[n];
         assign inject_ready_o[n]                   = rt_in_ready[n][noc_pkg::PORT_LOCAL];
      end
   end

   camera_tile u_cam_tile (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .pixel_i       (pixel_i),
      .pixel_valid_i (pixel_valid_i),
      .frame_start_i (frame_start_i),
      .out_flit_o    (cam_flit),
      .out_valid_o   (cam_valid),
      .out_ready_i   (cam_ready),
      .overrun_o     (cam_overrun_o)
   );

endmodule

// ==== testbench/system_2x2_cam_asserts.sv ====
/* Protocol checks for the 2x2 mesh top level
   Eject flit stability, quiet outputs in reset, sticky camera overrun */

`timescale 1ns/1ns
`include "noc_settings.svh"

module system_2x2_cam_asserts (
   input logic                            clk,
   input logic                            arst_n_i,
   input logic [`NOC_NODES-2:0]           inject_ready_o,
   input noc_pkg::flit_t [`NOC_NODES-1:0] eject_flit_o,
   input logic [`NOC_NODES-1:0]           eject_valid_o,
   input logic [`NOC_NODES-1:0]           eject_ready_i,
   input logic                            cam_overrun_o
);

   for (genvar n = 0; n < `NOC_NODES; n++) begin : g_eject
      // Stalled eject keeps valid and flit
      a_eject_hold : assert property (@(posedge clk) disable iff (!arst_n_i)
         eject_valid_o[n] && !eject_ready_i[n] |=>
            eject_valid_o[n] && $stable(eject_flit_o[n]))
         else $error("eject port %0d dropped or changed a stalled flit", n);
   end

   // Nothing offered or accepted while in reset
   a_reset_quiet : assert property (@(posedge clk)
      !arst_n_i |-> (eject_valid_o == '0) && (inject_ready_o == '0) && !cam_overrun_o)
      else $error("output active during reset");

   a_overrun_sticky : assert property (@(posedge clk) disable iff (!arst_n_i)
      cam_overrun_o |=> cam_overrun_o)   // Cleared only by reset
      else $error("camera overrun flag fell");

endmodule

bind system_2x2_cam system_2x2_cam_asserts u_asserts (
   .clk            (clk),
   .arst_n_i       (arst_n_i),
   .inject_ready_o (inject_ready_o),
   .eject_flit_o   (eject_flit_o),
   .eject_valid_o  (eject_valid_o),
   .eject_ready_i  (eject_ready_i),
   .cam_overrun_o  (cam_overrun_o)
);

// ==== testbench/tb_system_2x2_cam.sv ====
/* Testbench for the 2x2 mesh with camera tile
   Random traffic and pixels checked against per (src, dest) ordering queues */

`timescale 1ns/1ns
`include "noc_settings.svh"

module tb_system_2x2_cam;

   localparam int NPAIRS        = `NOC_NODES * `NOC_NODES;
   localparam int DIR_CYCLES    = 12 * 16;    // 12 single flits
   localparam int RAND_CYCLES   = 300;
   localparam int STRESS_CYCLES = 300;
   localparam int PIX_CYCLES    = 40 * 8;     // Paced pixels
   localparam int OVR_CYCLES    = 64 + 24;
   localparam int STIM_CYCLES   = 4 + DIR_CYCLES + RAND_CYCLES + STRESS_CYCLES
                                  + PIX_CYCLES + OVR_CYCLES;
   localparam int TIMEOUT       = 4 * STIM_CYCLES + 200;
   localparam int RDY_ALL       = 0;
   localparam int RDY_RANDOM    = 1;
   localparam int RDY_HOLD0     = 2;          // Eject 0 stalled, rest ready

   logic                            clk = 1'b0;
   logic                            arst_n_i;
   noc_pkg::flit_t [`NOC_NODES-2:0] inject_flit_i;
   logic [`NOC_NODES-2:0]           inject_valid_i;
   logic [`NOC_NODES-2:0]           inject_ready_o;
   noc_pkg::flit_t [`NOC_NODES-1:0] eject_flit_o;
   logic [`NOC_NODES-1:0]           eject_valid_o;
   logic [`NOC_NODES-1:0]           eject_ready_i;
   logic [7:0]                      pixel_i;
   logic                            pixel_valid_i;
   logic                            frame_start_i;
   logic                            cam_overrun_o;

   noc_pkg::flit_t exp_q [NPAIRS][$];        // Index src * NODES + dest
   logic [31:0]    rng_q = 32'd81539;
   int             cycle_cnt = 0;
   string          test_name = "reset";
   logic [2:0]     inj_fire = '0;            // Handshake seen at last falling edge
   logic [2:0]     inj_busy = '0;            // Presented, not yet taken
   logic           inj_on = 1'b0;
   int             rdy_mode = RDY_ALL;
   logic           stress_on = 1'b0;
   logic           saw_block = 1'b0;
   logic           dir_go = 1'b0;            // One directed flit waiting
   int             dir_port = 0;
   noc_pkg::flit_t dir_flit;
   logic           pix_go = 1'b0;
   logic [7:0]     pix_byte = '0;
   logic           fs_go = 1'b0;
   logic           cam_check_on = 1'b1;
   int             cam_cnt = 0;
   logic [`NOC_PAYLOAD_WIDTH-1:0] cam_word = '0;

   system_2x2_cam dut (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .inject_flit_i  (inject_flit_i),
      .inject_valid_i (inject_valid_i),
      .inject_ready_o (inject_ready_o),
      .eject_flit_o   (eject_flit_o),
      .eject_valid_o  (eject_valid_o),
      .eject_ready_i  (eject_ready_i),
      .pixel_i        (pixel_i),
      .pixel_valid_i  (pixel_valid_i),
      .frame_start_i  (frame_start_i),
      .cam_overrun_o  (cam_overrun_o)
   );

   always #10 clk = ~clk;

   task automatic abort_run();
      $display("Errors found");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_flit(input string name, input noc_pkg::flit_t exp,
                             input noc_pkg::flit_t act);
      if (act !== exp) begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Fail %s: expected %b, actual %b", name, exp, act);
         abort_run();
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   task automatic next_rand(output logic [31:0] r);
      rng_q = xorshift32(rng_q);
      r     = rng_q;
   endtask

   function automatic bit all_empty();
      for (int i = 0; i < NPAIRS; i++) begin
         if (exp_q[i].size() != 0) return 1'b0;
      end
      return 1'b1;
   endfunction

   // One clock of stimulus, all DUT inputs change right after the rising edge
   task automatic drive_cycle();
      logic [31:0]    r;
      logic [31:0]    pay;
      noc_pkg::flit_t f;
      @(posedge clk);
      for (int p = 0; p < 3; p++) begin
         if (inj_fire[p]) inj_busy[p] = 1'b0;   // Taken on this edge
         next_rand(r);
         next_rand(pay);
         if (!inj_busy[p]) begin
            if (dir_go && dir_port == p) begin
               inject_flit_i[p]  <= dir_flit;
               inject_valid_i[p] <= 1'b1;
               inj_busy[p]        = 1'b1;
               dir_go             = 1'b0;
            end else if (inj_on && r[1:0] != 2'b00) begin  // Three in four
               f.dest    = r[3:2];
               f.src     = noc_pkg::node_addr_t'(p);
               f.kind    = noc_pkg::FLIT_DATA;
               f.payload = pay;
               inject_flit_i[p]  <= f;
               inject_valid_i[p] <= 1'b1;
               inj_busy[p]        = 1'b1;
            end else begin
               inject_valid_i[p] <= 1'b0;
            end
         end
      end
      next_rand(r);
      case (rdy_mode)
         RDY_RANDOM: eject_ready_i <= r[3:0] & r[7:4];   // About one in four
         RDY_HOLD0:  eject_ready_i <= 4'b1110;
         default:    eject_ready_i <= 4'b1111;
      endcase
      pixel_valid_i <= pix_go;
      pixel_i       <= pix_byte;
      frame_start_i <= fs_go;
      pix_go = 1'b0;   // One-shot strobes
      fs_go  = 1'b0;
   endtask

   // Runs until every presented and expected flit has come out
   task automatic wait_drained();
      do begin
         drive_cycle();
      end while (!(all_empty() && inj_busy == 3'b000 && !dir_go));
   endtask

   task automatic send_one(input int src, input int dest);
      logic [31:0] r;
      next_rand(r);
      dir_flit.dest    = noc_pkg::node_addr_t'(dest);
      dir_flit.src     = noc_pkg::node_addr_t'(src);
      dir_flit.kind    = noc_pkg::FLIT_DATA;
      dir_flit.payload = r;
      dir_port         = src;
      dir_go           = 1'b1;
      wait_drained();
   endtask

   task automatic pace_pixel();
      logic [31:0] r;
      next_rand(r);
      pix_go   = 1'b1;
      pix_byte = r[7:0];
      repeat (8) drive_cycle();   // Strobe then seven idle cycles
   endtask

   task automatic start_frame();
      fs_go = 1'b1;
      drive_cycle();
   endtask

   // Model update at the falling edge, transfers land on the next rising edge
   always @(negedge clk) begin : monitor
      noc_pkg::flit_t got;
      noc_pkg::flit_t pix;
      int             idx;
      for (int p = 0; p < 3; p++) begin
         inj_fire[p] = inject_valid_i[p] && inject_ready_o[p];
         if (inj_fire[p]) begin
            exp_q[p * `NOC_NODES + int'(inject_flit_i[p].dest)].push_back(inject_flit_i[p]);
         end
         if (stress_on && inject_valid_i[p] && !inject_ready_o[p]) saw_block = 1'b1;
      end
      // Camera packing, first pixel lowest
      if (frame_start_i) cam_cnt = 0;
      if (pixel_valid_i) begin
         cam_word[cam_cnt*8 +: 8] = pixel_i;
         if (cam_cnt == `PIXELS_PER_FLIT - 1) begin
            pix.dest    = noc_pkg::node_addr_t'(`CAM_DEST_NODE);
            pix.src     = noc_pkg::node_addr_t'(`CAM_NODE);
            pix.kind    = noc_pkg::FLIT_PIXEL;
            pix.payload = cam_word;
            if (cam_check_on) exp_q[`CAM_NODE * `NOC_NODES + `CAM_DEST_NODE].push_back(pix);
            cam_cnt = 0;
         end else begin
            cam_cnt++;
         end
      end
      for (int n = 0; n < `NOC_NODES; n++) begin
         if (eject_valid_o[n] && eject_ready_i[n]) begin
            got = eject_flit_o[n];
            idx = int'(got.src) * `NOC_NODES + n;
            if (exp_q[idx].size() == 0) begin
               $display("Flit %h came out of eject port %0d with none expected", got, n);
               abort_run();
            end else begin
               check_flit(test_name, exp_q[idx].pop_front(), got);
            end
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt == TIMEOUT) begin
         $display("Timeout after %0d cycles, traffic did not drain", cycle_cnt);
         abort_run();
      end
   end

   initial begin
      logic [31:0] r;
      arst_n_i       <= 1'b0;
      inject_flit_i  <= '0;
      inject_valid_i <= '0;
      eject_ready_i  <= '1;
      pixel_i        <= '0;
      pixel_valid_i  <= 1'b0;
      frame_start_i  <= 1'b0;
      repeat (4) @(posedge clk);
      arst_n_i <= 1'b1;

      test_name = "directed";
      for (int s = 0; s < 3; s++) begin
         for (int d = 0; d < `NOC_NODES; d++) begin
            send_one(s, d);
         end
      end

      test_name = "random";
      inj_on    = 1'b1;
      repeat (RAND_CYCLES) drive_cycle();
      inj_on = 1'b0;
      wait_drained();

      test_name = "backpressure";
      stress_on = 1'b1;
      rdy_mode  = RDY_RANDOM;
      inj_on    = 1'b1;
      repeat (STRESS_CYCLES) drive_cycle();
      inj_on    = 1'b0;
      stress_on = 1'b0;
      rdy_mode  = RDY_ALL;
      wait_drained();
      if (!saw_block) begin
         $display("Inject ready never fell while ejects were stalled");
         abort_run();
      end

      test_name = "pixels";
      start_frame();
      repeat (16) pace_pixel();
      repeat (2) pace_pixel();
      start_frame();              // Half word discarded
      repeat (16) pace_pixel();
      wait_drained();
      @(negedge clk);
      check_flag("pixels overrun", 1'b0, cam_overrun_o);

      test_name    = "overrun";
      cam_check_on = 1'b0;
      rdy_mode     = RDY_HOLD0;
      repeat (64) begin
         next_rand(r);
         pix_go   = 1'b1;
         pix_byte = r[7:0];
         drive_cycle();
      end
      repeat (4) drive_cycle();
      @(negedge clk);
      check_flag("overrun rise", 1'b1, cam_overrun_o);
      repeat (16) drive_cycle();
      @(negedge clk);
      check_flag("overrun hold", 1'b1, cam_overrun_o);
      drive_cycle();

      if (all_empty()) begin
         $display("No errors");
         $finish;
      end else begin
         $display("Flits still expected at the end of the run");
         abort_run();
      end
   end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/noc_pkg.sv
verilog/noc_fifo.sv
verilog/noc_router.sv
verilog/camera_tile.sv
verilog/system_2x2_cam.sv
testbench/system_2x2_cam_asserts.sv
testbench/tb_system_2x2_cam.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the 2x2 mesh testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_system_2x2_cam -f sim.f
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

./obj_dir/Vtb_system_2x2_cam > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Errors found" sim.log; then
   echo "FAIL"
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "FAIL: simulator exited with status $sim_status"
   exit 1
fi
echo "PASS"
exit 0
